// File: hw/tcb_pkg.sv
// shared by all TCB files; widths are fixed at 32-bit data with 4 byte lanes
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_AW = 32;
  // data word width
  localparam int unsigned TCB_DW = 32;
  // one byte enable per data byte
  localparam int unsigned TCB_BW = TCB_DW / 8;

  typedef logic [TCB_AW-1:0] tcb_adr_t;
  typedef logic [TCB_DW-1:0] tcb_dat_t;
  typedef logic [TCB_BW-1:0] tcb_ben_t;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // subordinate select, 0 is memory, 1 is register block
  localparam int unsigned TCB_SEL_BIT = 31;
  // registers at word offsets 0 .. REG_NUM-1 of the register region
  localparam int unsigned REG_NUM = 4;

  ////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////

  // request fields, sampled on the transfer edge
  typedef struct packed {
    logic     wen;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
  } tcb_req_t;

  // response fields, valid DLY cycles after the transfer
  typedef struct packed {
    tcb_dat_t rdt;
    logic     err;
  } tcb_rsp_t;

endpackage

`default_nettype wire

// File: hw/tcb_if.sv
// DLY must match the DLY of every module on the bus; rdt/err are only meaningful DLY cycles after a transfer
`timescale 1ns/1ps
`default_nettype none

interface tcb_if
  import tcb_pkg::*;
#(
  // response delay in cycles, at least 1
  parameter int unsigned DLY = 2
)(
  input logic clk,
  input logic rst_n
);

  // handshake
  logic     vld;
  logic     rdy;
  // request
  logic     wen;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt;
  // response
  tcb_dat_t rdt;
  logic     err;

  // transfer cycle
  logic     trn;

  assign trn = vld & rdy;

  // manager side
  modport man (
    input  clk, rst_n, trn,
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err
  );

  // subordinate side, mirror of man
  modport sub (
    input  clk, rst_n, trn,
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err
  );

endinterface

`default_nettype wire

// File: hw/tcb_dec.sv
// two subordinates only, split on TCB_SEL_BIT; all three interfaces must share one DLY
`timescale 1ns/1ps
`default_nettype none

module tcb_dec
  import tcb_pkg::*;
(
  // from the manager
  tcb_if.sub man,
  // to the memory
  tcb_if.man mem,
  // to the register block
  tcb_if.man reg_sub
);

  // delay taken from the manager side
  localparam int unsigned DLY = man.DLY;

  // elaboration checks
  generate
    if (DLY < 1) $error("%m DLY must be at least 1");
    if (mem.DLY != DLY) $error("%m memory side DLY mismatch");
    if (reg_sub.DLY != DLY) $error("%m register side DLY mismatch");
  endgenerate

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  tcb_req_t req;
  logic     sel;

  // pack manager request
  assign req = '{wen: man.wen, adr: man.adr, ben: man.ben, wdt: man.wdt};

  // high selects the register block
  assign sel = req.adr[TCB_SEL_BIT];

  // vld only to the selected side
  assign mem.vld     = man.vld & ~sel;
  assign reg_sub.vld = man.vld &  sel;

  // other request fields shared
  assign mem.wen     = req.wen;
  assign mem.adr     = req.adr;
  assign mem.ben     = req.ben;
  assign mem.wdt     = req.wdt;
  assign reg_sub.wen = req.wen;
  assign reg_sub.adr = req.adr;
  assign reg_sub.ben = req.ben;
  assign reg_sub.wdt = req.wdt;

  // ready from whichever side is addressed
  assign man.rdy = sel ? reg_sub.rdy : mem.rdy;

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  // select bit follows its transfer through DLY stages
  logic [DLY-1:0] sel_dly;

  always_ff @(posedge man.clk) begin
    if (!man.rst_n) begin
      sel_dly <= '0;
    end else begin
      sel_dly[0] <= sel;
      for (int unsigned i = 1; i < DLY; i++) begin
        sel_dly[i] <= sel_dly[i-1];
      end
    end
  end

  // response from the side that took the transfer
  assign man.rdt = sel_dly[DLY-1] ? reg_sub.rdt : mem.rdt;
  assign man.err = sel_dly[DLY-1] ? reg_sub.err : mem.err;

endmodule

`default_nettype wire

// File: hw/tcb_mem.sv
// no wait states; addresses wrap modulo 2**MEM_AW words and adr[1:0] is ignored
`timescale 1ns/1ps
`default_nettype none

module tcb_mem
  import tcb_pkg::*;
#(
  // response delay, must match the interface
  parameter int unsigned DLY    = 2,
  // word address width
  parameter int unsigned MEM_AW = 6
)(
  tcb_if.sub bus
);

  generate
    if (DLY < 1) $error("%m DLY must be at least 1");
    if (DLY != bus.DLY) $error("%m DLY does not match the interface");
  endgenerate

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  tcb_dat_t          mem_q [2**MEM_AW];
  logic [MEM_AW-1:0] idx;

  // word index, upper bits dropped so access wraps
  assign idx = bus.adr[MEM_AW+1:2];

  // never stalls
  assign bus.rdy = bus.vld;

  // byte lane writes
  always_ff @(posedge bus.clk) begin
    if (bus.trn && bus.wen) begin
      for (int unsigned b = 0; b < TCB_BW; b++) begin
        if (bus.ben[b]) begin
          mem_q[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////////////////////////

  tcb_rsp_t       rsp_dly [DLY];
  logic [DLY-1:0] vld_dly;

  // marks stages that carry a real response
  always_ff @(posedge bus.clk) begin
    if (!bus.rst_n) begin
      vld_dly <= '0;
    end else begin
      vld_dly[0] <= bus.trn;
      for (int unsigned i = 1; i < DLY; i++) begin
        vld_dly[i] <= vld_dly[i-1];
      end
    end
  end

  // old word on a write, same edge as the update
  always_ff @(posedge bus.clk) begin
    rsp_dly[0] <= '{rdt: mem_q[idx], err: 1'b0};
    for (int unsigned i = 1; i < DLY; i++) begin
      rsp_dly[i] <= rsp_dly[i-1];
    end
  end

  // quiet bus between responses
  assign bus.rdt = vld_dly[DLY-1] ? rsp_dly[DLY-1].rdt : '0;
  assign bus.err = vld_dly[DLY-1] ? rsp_dly[DLY-1].err : 1'b0;

endmodule

`default_nettype wire

// File: hw/tcb_reg.sv
// every transfer waits one cycle; offsets at or above REG_NUM give err 1 and rdt 0 without side effects
`timescale 1ns/1ps
`default_nettype none

module tcb_reg
  import tcb_pkg::*;
#(
  // response delay, must match the interface
  parameter int unsigned DLY = 2
)(
  tcb_if.sub bus
);

  generate
    if (DLY < 1) $error("%m DLY must be at least 1");
    if (DLY != bus.DLY) $error("%m DLY does not match the interface");
  endgenerate

  // register index width
  localparam int unsigned REG_AW = $clog2(REG_NUM);

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  tcb_req_t                  req;
  logic [TCB_SEL_BIT-1-2:0]  off;
  logic [REG_AW-1:0]         idx;
  logic                      hit;

  assign req = '{wen: bus.wen, adr: bus.adr, ben: bus.ben, wdt: bus.wdt};

  // word offset inside the register region
  assign off = req.adr[TCB_SEL_BIT-1:2];
  assign idx = off[REG_AW-1:0];
  // mapped offsets only
  assign hit = (off < REG_NUM);

  // wait state, set while vld waits, cleared by the transfer
  logic wait_q;

  always_ff @(posedge bus.clk) begin
    if (!bus.rst_n) begin
      wait_q <= 1'b0;
    end else if (bus.trn) begin
      wait_q <= 1'b0;
    end else if (bus.vld) begin
      wait_q <= 1'b1;
    end
  end

  // second cycle of vld
  assign bus.rdy = bus.vld & wait_q;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  tcb_dat_t reg_q [REG_NUM];

  always_ff @(posedge bus.clk) begin
    if (!bus.rst_n) begin
      for (int unsigned r = 0; r < REG_NUM; r++) begin
        reg_q[r] <= '0;
      end
    end else if (bus.trn && req.wen && hit) begin
      // per byte lane
      for (int unsigned b = 0; b < TCB_BW; b++) begin
        if (req.ben[b]) begin
          reg_q[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////////////////////////

  tcb_rsp_t       rsp_dly [DLY];
  logic [DLY-1:0] vld_dly;

  always_ff @(posedge bus.clk) begin
    if (!bus.rst_n) begin
      vld_dly <= '0;
    end else begin
      vld_dly[0] <= bus.trn;
      for (int unsigned i = 1; i < DLY; i++) begin
        vld_dly[i] <= vld_dly[i-1];
      end
    end
  end

  // unmapped offset reads as zero with error
  always_ff @(posedge bus.clk) begin
    rsp_dly[0] <= hit ? '{rdt: reg_q[idx], err: 1'b0} : '{rdt: '0, err: 1'b1};
    for (int unsigned i = 1; i < DLY; i++) begin
      rsp_dly[i] <= rsp_dly[i-1];
    end
  end

  assign bus.rdt = vld_dly[DLY-1] ? rsp_dly[DLY-1].rdt : '0;
  assign bus.err = vld_dly[DLY-1] ? rsp_dly[DLY-1].err : 1'b0;

endmodule

`default_nettype wire

// File: hw/tcb_top.sv
// single manager; rdt/err are valid exactly DLY cycles after each vld&rdy edge and ignored otherwise
`timescale 1ns/1ps
`default_nettype none

module tcb_top
  import tcb_pkg::*;
#(
  // response delay for every subordinate
  parameter int unsigned DLY    = 2,
  // memory word address width
  parameter int unsigned MEM_AW = 6
)(
  input  logic     clk,
  input  logic     rst_n,
  // request
  input  logic     vld,
  input  logic     wen,
  input  tcb_adr_t adr,
  input  tcb_ben_t ben,
  input  tcb_dat_t wdt,
  // handshake and response
  output logic     rdy,
  output tcb_dat_t rdt,
  output logic     err
);

  ////////////////////////////////////////////////////////////
  // bus instances
  ////////////////////////////////////////////////////////////

  tcb_if #(.DLY(DLY)) bus_man (.clk(clk), .rst_n(rst_n));
  tcb_if #(.DLY(DLY)) bus_mem (.clk(clk), .rst_n(rst_n));
  tcb_if #(.DLY(DLY)) bus_reg (.clk(clk), .rst_n(rst_n));

  // plain ports onto the manager bus
  assign bus_man.vld = vld;
  assign bus_man.wen = wen;
  assign bus_man.adr = adr;
  assign bus_man.ben = ben;
  assign bus_man.wdt = wdt;
  assign rdy         = bus_man.rdy;
  assign rdt         = bus_man.rdt;
  assign err         = bus_man.err;

  ////////////////////////////////////////////////////////////
  // decoder and subordinates
  ////////////////////////////////////////////////////////////

  tcb_dec dec_i (
    .man     (bus_man),
    .mem     (bus_mem),
    .reg_sub (bus_reg)
  );

  tcb_mem #(.DLY(DLY), .MEM_AW(MEM_AW)) mem_i (
    .bus (bus_mem)
  );

  tcb_reg #(.DLY(DLY)) reg_i (
    .bus (bus_reg)
  );

endmodule

`default_nettype wire

// File: dv/tcb_clk.sv
// free-running 4 ns clock; rst_n is released on a falling edge after RST_CYC rising edges
`timescale 1ns/1ps
`default_nettype none

module tcb_clk #(
  // half period in ns
  parameter int unsigned HALF    = 2,
  // rising edges held in reset
  parameter int unsigned RST_CYC = 2
)(
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF) clk = ~clk;
  end

  // release away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tcb_assert.sv
// sampled on the rising edge and off during reset; the register side is taken from adr[TCB_SEL_BIT]
`timescale 1ns/1ps
`default_nettype none

module tcb_assert
  import tcb_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     vld,
  input logic     rdy,
  input logic     wen,
  input tcb_adr_t adr,
  input tcb_ben_t ben,
  input tcb_dat_t wdt
);

  // request held through a wait cycle
  hold_req: assert property (@(posedge clk) disable iff (!rst_n)
    vld && !rdy |=> vld && $stable({wen, adr, ben, wdt}))
    else $error("request changed while waiting for rdy");

  // rdy only answers a request
  rdy_vld: assert property (@(posedge clk) disable iff (!rst_n) rdy |-> vld)
    else $error("rdy high without vld");

  // register block waits one cycle, never more
  reg_wait: assert property (@(posedge clk) disable iff (!rst_n)
    vld && adr[TCB_SEL_BIT] && !rdy |=> rdy)
    else $error("register side not ready after its wait cycle");

endmodule

bind tcb_top tcb_assert assert_i (
  .clk   (clk),
  .rst_n (rst_n),
  .vld   (vld),
  .rdy   (rdy),
  .wen   (wen),
  .adr   (adr),
  .ben   (ben),
  .wdt   (wdt)
);

`default_nettype wire

// File: dv/tcb_tb.sv
// DLY and MEM_AW below must match the DUT; memory words are only read after the table writes them
`timescale 1ns/1ps
`default_nettype none

module tcb_tb
  import tcb_pkg::*;
();

  localparam int unsigned DLY    = 2;
  localparam int unsigned MEM_AW = 6;

  ////////////////////////////////////////////////////////////
  // table data
  ////////////////////////////////////////////////////////////

  localparam tcb_adr_t REG_BASE = 32'h8000_0000;
  localparam tcb_dat_t W0 = 32'h1234_5678;
  localparam tcb_dat_t W1 = 32'hdead_beef;
  localparam tcb_dat_t W2 = 32'ha5a5_0ff0;
  // partial write pattern
  localparam tcb_dat_t P  = 32'hffee_ddcc;
  localparam tcb_dat_t RV [REG_NUM] = '{
    32'h0bad_f00d, 32'hc001_d00d, 32'h5555_aaaa, 32'h8765_4321
  };
  // lanes 0 and 2 of P over W0
  localparam tcb_dat_t M0P = {W0[31:24], P[23:16], W0[15:8], P[7:0]};
  // lanes 2 and 3 of P over register 2
  localparam tcb_dat_t R2P = {P[31:16], RV[2][15:0]};

  typedef struct packed {
    tcb_req_t req;
    tcb_dat_t rdt;
    logic     err;
    // no idle cycles before this row
    logic     b2b;
  } row_t;

  // transfer waiting for its response
  typedef struct packed {
    int unsigned row;
    int unsigned due;
  } pend_t;

  logic     clk;
  logic     rst_n;
  logic     vld;
  logic     wen;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt;
  logic     rdy;
  tcb_dat_t rdt;
  logic     err;

  row_t        rows [$];
  pend_t       pend [$];
  // falling edges seen so far
  int unsigned cyc    = 0;
  int unsigned limit  = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  logic [31:0] rnd    = 32'hfbf09e77;

  tcb_clk clk_i (.clk(clk), .rst_n(rst_n));

  tcb_top #(.DLY(DLY), .MEM_AW(MEM_AW)) tcb_top_i (
    .clk(clk), .rst_n(rst_n), .vld(vld), .wen(wen), .adr(adr), .ben(ben), .wdt(wdt),
    .rdy(rdy), .rdt(rdt), .err(err)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_write(input tcb_adr_t a, input tcb_ben_t b, input tcb_dat_t d, input logic e);
    rows.push_back('{req: '{wen: 1'b1, adr: a, ben: b, wdt: d}, rdt: '0, err: e, b2b: 1'b0});
  endtask

  task automatic add_read(input tcb_adr_t a, input tcb_dat_t d, input logic e, input logic b2b);
    rows.push_back('{req: '{wen: 1'b0, adr: a, ben: 4'hf, wdt: '0}, rdt: d, err: e, b2b: b2b});
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_rdt(input int unsigned row, input tcb_dat_t got, input tcb_dat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR rdt row %0d: got %h, expected %h", row, got, exp);
    end
  endtask

  task automatic check_err(input int unsigned row, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR err row %0d: got %h, expected %h", row, got, exp);
    end
  endtask

  // cycles of vld with rdy low before the transfer
  task automatic check_wait(input int unsigned row, input int unsigned got, input int unsigned exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR rdy row %0d: low cycles got %h, expected %h", row, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin : main
    int unsigned stall;
    int unsigned gap;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    ben = '0;
    wdt = '0;
    // registers cleared by reset
    for (int r = 0; r < REG_NUM; r++) begin
      add_read(REG_BASE + 4 * r, '0, 1'b0, 1'b0);
    end
    // memory full words, then lanes 0 and 2, then a wrapped address
    add_write(32'h10, 4'hf, W0, 1'b0);
    add_read(32'h10, W0, 1'b0, 1'b0);
    add_write(32'h24, 4'hf, W1, 1'b0);
    add_read(32'h24, W1, 1'b0, 1'b0);
    add_write(32'h10, 4'b0101, P, 1'b0);
    add_read(32'h10, M0P, 1'b0, 1'b0);
    add_write(32'h04, 4'hf, W2, 1'b0);
    add_read(32'h104, W2, 1'b0, 1'b0);
    // independent registers
    for (int r = 0; r < REG_NUM; r++) begin
      add_write(REG_BASE + 4 * r, 4'hf, RV[r], 1'b0);
    end
    for (int r = 0; r < REG_NUM; r++) begin
      add_read(REG_BASE + 4 * r, RV[r], 1'b0, 1'b0);
    end
    add_write(REG_BASE + 8, 4'b1100, P, 1'b0);
    add_read(REG_BASE + 8, R2P, 1'b0, 1'b0);
    // unmapped offsets must leave every register as it was
    add_write(REG_BASE + 4 * REG_NUM, 4'hf, W1, 1'b1);
    add_read(REG_BASE + 4 * REG_NUM, '0, 1'b1, 1'b0);
    add_read(REG_BASE + 32'h40, '0, 1'b1, 1'b0);
    for (int r = 0; r < REG_NUM; r++) begin
      add_read(REG_BASE + 4 * r, (r == 2) ? R2P : RV[r], 1'b0, 1'b0);
    end
    // mixed reads with no idle cycles
    add_read(32'h10, M0P, 1'b0, 1'b1);
    add_read(REG_BASE + 4, RV[1], 1'b0, 1'b1);
    add_read(32'h24, W1, 1'b0, 1'b1);
    add_read(REG_BASE + 12, RV[3], 1'b0, 1'b1);
    add_read(32'h104, W2, 1'b0, 1'b1);
    add_read(REG_BASE, RV[0], 1'b0, 1'b1);
    // worst case per row is idle, wait and response cycles
    limit = rows.size() * (4 + 2 + DLY) + 20;

    @(posedge rst_n);
    for (int unsigned i = 0; i < rows.size(); i++) begin
      rnd = next_random(rnd);
      gap = rows[i].b2b ? 0 : rnd[1:0];
      repeat (gap) begin
        @(negedge clk);
        vld = 1'b0;
      end
      @(negedge clk);
      vld = 1'b1;
      wen = rows[i].req.wen;
      adr = rows[i].req.adr;
      ben = rows[i].req.ben;
      wdt = rows[i].req.wdt;
      stall = 0;
      @(posedge clk);
      while (!rdy) begin
        stall++;
        @(posedge clk);
      end
      // response due on the DLY-th falling edge from here
      pend.push_back('{row: i, due: cyc + DLY});
      check_wait(i, stall, rows[i].req.adr[TCB_SEL_BIT] ? 1 : 0);
    end
    @(negedge clk);
    vld = 1'b0;
    while (pend.size() != 0) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // response check and timeout
  ////////////////////////////////////////////////////////////

  // response lands mid-cycle on its due falling edge
  always @(negedge clk) begin : check_rsp
    pend_t cur;
    cyc = cyc + 1;
    if (pend.size() != 0 && pend[0].due == cyc) begin
      cur = pend.pop_front();
      // write responses carry no data
      if (!rows[cur.row].req.wen) begin
        check_rdt(cur.row, rdt, rows[cur.row].rdt);
      end
      check_err(cur.row, err, rows[cur.row].err);
    end
  end

  initial begin : watchdog
    while (limit == 0 || cyc < limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles, errors %0d", limit, errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/tcb_pkg.sv
hw/tcb_if.sv
hw/tcb_dec.sv
hw/tcb_mem.sv
hw/tcb_reg.sv
hw/tcb_top.sv
dv/tcb_clk.sv
dv/tcb_assert.sv
dv/tcb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the TCB testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tcb_tb -f tb.f -o tcb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/tcb_sim 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
